//--- rtl/mmuPkg.sv
`default_nettype none

package mmuPkg;

  localparam int addrWidth = 32;
  localparam int tableBaseWidth = 18;
  localparam int domainWidth = 4;
  localparam int domainLsb = 5;  // Domain field of a level-1 descriptor
  localparam int apWidth = 2;

  // Coprocessor register numbers
  localparam logic [3:0] cp15DomainReg = 4'd3;
  localparam logic [3:0] cp15FsrReg = 4'd5;
  localparam logic [3:0] cp15FarReg = 4'd6;

  typedef enum logic [3:0] {
    Idle,
    SectionAccess,
    CoarseFetch,
    FineFetch,
    SmallAccess,
    LargeAccess,
    TinyAccess,
    FaultFsr,
    FaultFar
  } walkState;

  // Status codes as written to the FSR
  typedef enum logic [3:0] {
    alignFault         = 4'b0001,
    translationSection = 4'b0101,
    translationPage    = 4'b0111,
    domainSection      = 4'b1001,
    domainPage         = 4'b1011,
    permissionSection  = 4'b1101,
    permissionPage     = 4'b1111,
    externalFirst      = 4'b1100,
    externalSecond     = 4'b1110
  } faultCode;

  // Level-1 names; at level 2, 01 is large, 10 small and 11 tiny
  typedef enum logic [1:0] {
    invalid = 2'b00,
    coarse  = 2'b01,
    section = 2'b10,
    fine    = 2'b11
  } descType;

  typedef struct packed {
    logic [addrWidth-1:0] addr;
    logic req;
    logic write;
    logic wordAccess;
    logic dataAccess;  // Low for an instruction fetch
    logic supMode;
  } cpuBus;

  typedef struct packed {
    logic [addrWidth-1:0] addr;
    logic req;
    logic write;
  } sysBus;

  typedef struct packed {
    logic en;
    logic [3:0] addr;
    logic [addrWidth-1:0] data;
  } cp15Write;

  typedef struct packed {
    logic enable;
    logic sBit;
    logic rBit;
  } mmuControl;

endpackage

`default_nettype wire

//--- rtl/permissionChecker.sv
`timescale 1ns/10ps
`default_nettype none

module permissionChecker (
  input  mmuPkg::walkState state,
  input  logic [31:0] descriptor,
  input  logic [mmuPkg::addrWidth-1:0] va,
  input  logic [mmuPkg::domainWidth-1:0] domain,
  input  logic [31:0] domainAccess,
  input  logic sBit,
  input  logic rBit,
  input  logic supMode,
  input  logic write,
  output logic domainFault,
  output logic permissionFault
);

  logic [1:0] domainPerm;
  logic [1:0] subpage;
  logic [mmuPkg::apWidth-1:0] ap;
  logic apFault;
  logic inWalk;
  logic inAccess;

  assign inAccess = state inside {mmuPkg::SectionAccess, mmuPkg::SmallAccess,
                                  mmuPkg::LargeAccess, mmuPkg::TinyAccess};
  assign inWalk = inAccess || (state == mmuPkg::CoarseFetch) ||
                  (state == mmuPkg::FineFetch);

  // Two bits per domain
  assign domainPerm = domainAccess[{domain, 1'b0} +: 2];

  // Subpage index, 16KB steps for large pages and 1KB for small
  assign subpage = (state == mmuPkg::LargeAccess) ? va[15:14] : va[11:10];

  always_comb begin
    case (state)
      mmuPkg::SectionAccess: ap = descriptor[11:10];
      mmuPkg::SmallAccess, mmuPkg::LargeAccess:
        ap = descriptor[{subpage, 1'b0} + 4 +: mmuPkg::apWidth];  // ap0 sits at 5:4
      mmuPkg::TinyAccess: ap = descriptor[5:4];
      default: ap = 2'b11;
    endcase
  end

  always_comb begin
    case (ap)
      2'b00: begin
        case ({sBit, rBit})
          2'b10:   apFault = !supMode || write;  // Supervisor read only
          2'b01:   apFault = write;              // Read only for all
          default: apFault = 1'b1;
        endcase
      end
      2'b01:   apFault = !supMode;
      2'b10:   apFault = !supMode && write;  // User read only
      default: apFault = 1'b0;
    endcase
  end

  // 00 no access, 10 reserved
  assign domainFault = inWalk && !domainPerm[0];
  assign permissionFault = inAccess && (domainPerm == 2'b01) && apFault;  // Client only

endmodule

`default_nettype wire

//--- rtl/tableWalker.sv
`timescale 1ns/10ps
`default_nettype none

module tableWalker (
  input  logic clk,
  input  logic reset,
  input  mmuPkg::cpuBus cpu,
  input  logic enable,
  input  logic [mmuPkg::tableBaseWidth-1:0] tableBase,
  input  logic [31:0] hRData,
  input  logic busReady,
  input  logic extAbort,
  input  logic domainFault,
  input  logic permissionFault,
  output mmuPkg::sysBus sys,
  output logic cpuReady,
  output mmuPkg::walkState state,
  output logic [31:0] descriptor,
  output logic [mmuPkg::domainWidth-1:0] domain,
  output logic faultStrobe,
  output mmuPkg::faultCode code
);

  mmuPkg::walkState nextState;
  mmuPkg::walkState pageState;
  mmuPkg::descType fetchedType;
  logic [mmuPkg::addrWidth-1:0] va;
  logic [mmuPkg::addrWidth-1:0] physAddr;
  logic misaligned;
  logic l1Done;
  logic l2Done;
  logic inFetch;
  logic inAccess;

  assign va = cpu.addr;
  assign fetchedType = mmuPkg::descType'(hRData[1:0]);
  assign inFetch = (state == mmuPkg::CoarseFetch) || (state == mmuPkg::FineFetch);
  assign inAccess = state inside {mmuPkg::SectionAccess, mmuPkg::SmallAccess,
                                  mmuPkg::LargeAccess, mmuPkg::TinyAccess};
  assign misaligned = cpu.wordAccess && (va[1:0] != 2'b00);
  assign l1Done = enable && (state == mmuPkg::Idle) && cpu.req && !misaligned && busReady;
  assign l2Done = inFetch && busReady;

  // Level-2 type field, same bit pattern as level 1
  always_comb begin
    case (fetchedType)
      mmuPkg::coarse: pageState = mmuPkg::LargeAccess;
      mmuPkg::fine:   pageState = mmuPkg::TinyAccess;
      default:        pageState = mmuPkg::SmallAccess;
    endcase
  end

  // Fault priority follows the order of the checks
  always_comb begin
    faultStrobe = 1'b0;
    code = mmuPkg::alignFault;
    if (enable) begin
      case (state)
        mmuPkg::Idle: begin
          if (cpu.req && misaligned) begin
            faultStrobe = 1'b1;
            code = mmuPkg::alignFault;
          end else if (l1Done && extAbort) begin
            faultStrobe = 1'b1;
            code = mmuPkg::externalFirst;
          end else if (l1Done && fetchedType == mmuPkg::invalid) begin
            faultStrobe = 1'b1;
            code = mmuPkg::translationSection;
          end
        end
        mmuPkg::CoarseFetch, mmuPkg::FineFetch: begin
          if (l2Done && extAbort) begin
            faultStrobe = 1'b1;
            code = mmuPkg::externalSecond;
          end else if (l2Done && fetchedType == mmuPkg::invalid) begin
            faultStrobe = 1'b1;
            code = mmuPkg::translationPage;
          end else if (l2Done && domainFault) begin
            faultStrobe = 1'b1;
            code = mmuPkg::domainPage;
          end
        end
        mmuPkg::SectionAccess: begin
          if (domainFault) begin
            faultStrobe = 1'b1;
            code = mmuPkg::domainSection;
          end else if (permissionFault) begin
            faultStrobe = 1'b1;
            code = mmuPkg::permissionSection;
          end
        end
        mmuPkg::SmallAccess, mmuPkg::LargeAccess, mmuPkg::TinyAccess: begin
          if (permissionFault) begin
            faultStrobe = 1'b1;
            code = mmuPkg::permissionPage;
          end
        end
        default: ;
      endcase
    end
  end

  always_comb begin
    nextState = state;
    if (!enable) begin
      nextState = mmuPkg::Idle;
    end else if (faultStrobe) begin
      nextState = mmuPkg::FaultFsr;
    end else begin
      case (state)
        mmuPkg::Idle: begin
          if (l1Done) begin
            case (fetchedType)
              mmuPkg::coarse: nextState = mmuPkg::CoarseFetch;
              mmuPkg::fine:   nextState = mmuPkg::FineFetch;
              default:        nextState = mmuPkg::SectionAccess;
            endcase
          end
        end
        mmuPkg::CoarseFetch, mmuPkg::FineFetch: begin
          if (busReady) nextState = pageState;
        end
        mmuPkg::SectionAccess, mmuPkg::SmallAccess,
        mmuPkg::LargeAccess, mmuPkg::TinyAccess: begin
          if (busReady) nextState = mmuPkg::Idle;
        end
        mmuPkg::FaultFsr: nextState = mmuPkg::FaultFar;
        default:          nextState = mmuPkg::Idle;
      endcase
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) state <= mmuPkg::Idle;
    else state <= nextState;
  end

  always_ff @(posedge clk) begin
    if (l1Done || l2Done) descriptor <= hRData;
    if (l1Done) domain <= hRData[mmuPkg::domainLsb +: mmuPkg::domainWidth];  // Kept for level 2
  end

  always_comb begin
    case (state)
      mmuPkg::Idle:          physAddr = {tableBase, va[31:20], 2'b00};
      mmuPkg::SectionAccess: physAddr = {descriptor[31:20], va[19:0]};
      mmuPkg::CoarseFetch:   physAddr = {descriptor[31:10], va[19:12], 2'b00};
      mmuPkg::FineFetch:     physAddr = {descriptor[31:12], va[19:10], 2'b00};
      mmuPkg::SmallAccess:   physAddr = {descriptor[31:12], va[11:0]};
      mmuPkg::LargeAccess:   physAddr = {descriptor[31:16], va[15:0]};
      mmuPkg::TinyAccess:    physAddr = {descriptor[31:10], va[9:0]};
      default:               physAddr = va;
    endcase
  end

  // Fetches stay requested until completion, even when they fault
  assign sys.addr = physAddr;
  assign sys.req = enable && (((state == mmuPkg::Idle) && cpu.req && !misaligned) ||
                              inFetch || (inAccess && !faultStrobe));
  assign sys.write = enable && inAccess && !faultStrobe && cpu.write;
  assign cpuReady = inAccess && busReady && !faultStrobe;

endmodule

`default_nettype wire

//--- rtl/faultReporter.sv
`timescale 1ns/10ps
`default_nettype none

module faultReporter (
  input  logic clk,
  input  logic reset,
  input  logic faultStrobe,
  input  mmuPkg::faultCode code,
  input  logic [mmuPkg::domainWidth-1:0] domain,
  input  logic [mmuPkg::addrWidth-1:0] va,
  input  logic dataAccess,
  output logic dataAbort,
  output logic prefetchAbort,
  output mmuPkg::cp15Write cp15
);

  mmuPkg::faultCode savedCode;
  logic [mmuPkg::domainWidth-1:0] savedDomain;
  logic [mmuPkg::addrWidth-1:0] savedVa;
  logic [1:0] step;
  logic [mmuPkg::addrWidth-1:0] fsrValue;

  assign dataAbort = faultStrobe && dataAccess;
  assign prefetchAbort = faultStrobe && !dataAccess;

  // Bit 0 FSR cycle, bit 1 FAR cycle
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      step <= 2'b00;
    end else begin
      step <= {step[0], faultStrobe};
    end
  end

  always_ff @(posedge clk) begin
    if (faultStrobe) begin
      savedCode <= code;
      savedDomain <= domain;
      savedVa <= va;  // Virtual address of the faulting access
    end
  end

  assign fsrValue = {{(mmuPkg::addrWidth - mmuPkg::domainWidth - 4){1'b0}},
                     savedDomain, savedCode};

  always_comb begin
    cp15.en = |step;
    cp15.addr = mmuPkg::cp15DomainReg;  // Domain register selected when idle
    cp15.data = '0;
    if (step[0]) begin
      cp15.addr = mmuPkg::cp15FsrReg;
      cp15.data = fsrValue;
    end else if (step[1]) begin
      cp15.addr = mmuPkg::cp15FarReg;
      cp15.data = savedVa;
    end
  end

endmodule

`default_nettype wire

//--- rtl/mmuTop.sv
`timescale 1ns/10ps
`default_nettype none

module mmuTop (
  input  logic clk,
  input  logic reset,
  input  mmuPkg::cpuBus cpu,
  input  mmuPkg::mmuControl control,
  input  logic [mmuPkg::tableBaseWidth-1:0] tableBase,
  input  logic [31:0] domainAccess,
  input  logic [31:0] hRData,
  input  logic busReady,
  input  logic extAbort,
  output mmuPkg::sysBus sys,
  output logic cpuReady,
  output mmuPkg::cp15Write cp15,
  output logic dataAbort,
  output logic prefetchAbort
);

  mmuPkg::sysBus walkSys;
  logic walkReady;
  mmuPkg::walkState state;
  logic [31:0] descriptor;
  logic [mmuPkg::domainWidth-1:0] domain;
  logic domainFault;
  logic permissionFault;
  logic faultStrobe;
  mmuPkg::faultCode code;

  tableWalker u_tableWalker (
    .clk(clk), .reset(reset), .cpu(cpu), .enable(control.enable),
    .tableBase(tableBase), .hRData(hRData), .busReady(busReady),
    .extAbort(extAbort), .domainFault(domainFault),
    .permissionFault(permissionFault), .sys(walkSys), .cpuReady(walkReady),
    .state(state), .descriptor(descriptor), .domain(domain),
    .faultStrobe(faultStrobe), .code(code)
  );

  permissionChecker u_permissionChecker (
    .state(state), .descriptor(descriptor), .va(cpu.addr), .domain(domain),
    .domainAccess(domainAccess), .sBit(control.sBit), .rBit(control.rBit),
    .supMode(cpu.supMode), .write(cpu.write),
    .domainFault(domainFault), .permissionFault(permissionFault)
  );

  faultReporter u_faultReporter (
    .clk(clk), .reset(reset), .faultStrobe(faultStrobe), .code(code),
    .domain(domain), .va(cpu.addr), .dataAccess(cpu.dataAccess),
    .dataAbort(dataAbort), .prefetchAbort(prefetchAbort), .cp15(cp15)
  );

  // MMU off: processor drives the system bus directly
  always_comb begin
    if (control.enable) begin
      sys = walkSys;
      cpuReady = walkReady;
    end else begin
      sys.addr = cpu.addr;
      sys.req = cpu.req;
      sys.write = cpu.write;
      cpuReady = busReady;
    end
  end

endmodule

`default_nettype wire

//--- verification/mmuTop_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module mmuTopAsserts (
  input logic clk,
  input logic reset,
  input logic [31:0] sysAddr,
  input logic sysReq,
  input logic busReady,
  input logic dataAbort,
  input logic prefetchAbort,
  input logic cp15En,
  input logic [3:0] cp15Addr
);

  // A stalled transfer keeps its request and address
  property stableWhileStalled;
    @(posedge clk) disable iff (reset)
      (sysReq && !busReady) |=> (sysReq && $stable(sysAddr));
  endproperty

  // FSR write right after an abort
  property fsrAfterAbort;
    @(posedge clk) disable iff (reset)
      (dataAbort || prefetchAbort) |=> (cp15En && cp15Addr == 4'd5);
  endproperty

  property farAfterFsr;
    @(posedge clk) disable iff (reset)
      (cp15En && cp15Addr == 4'd5) |=> (cp15En && cp15Addr == 4'd6);
  endproperty

  property dataAbortPulse;
    @(posedge clk) disable iff (reset)
      dataAbort |=> !dataAbort;
  endproperty

  property prefetchAbortPulse;
    @(posedge clk) disable iff (reset)
      prefetchAbort |=> !prefetchAbort;
  endproperty

  assert property (stableWhileStalled) else $error("System bus address moved during a stall");
  assert property (fsrAfterAbort) else $error("Abort not followed by the FSR write");
  assert property (farAfterFsr) else $error("FSR write not followed by the FAR write");
  assert property (dataAbortPulse) else $error("dataAbort longer than one cycle");
  assert property (prefetchAbortPulse) else $error("prefetchAbort longer than one cycle");

endmodule

bind mmuTop mmuTopAsserts u_mmuTopAsserts (
  .clk(clk), .reset(reset), .sysAddr(sys.addr), .sysReq(sys.req),
  .busReady(busReady), .dataAbort(dataAbort), .prefetchAbort(prefetchAbort),
  .cp15En(cp15.en), .cp15Addr(cp15.addr)
);

`default_nettype wire

//--- verification/mmuTb.sv
`timescale 1ns/10ps
`default_nettype none

module mmuTb;

  // Reset, pass-through, then about 100 accesses of at most 40 cycles each
  localparam int timeoutCycles = 16 + 60 + 100 * 40;

  logic clk = 1'b0;
  logic reset = 1'b1;
  mmuPkg::cpuBus cpu;
  mmuPkg::mmuControl control;
  logic [mmuPkg::tableBaseWidth-1:0] tableBase;
  logic [31:0] domainAccess;
  logic [31:0] hRData = 32'h0;
  logic busReady;
  logic extAbort;
  mmuPkg::sysBus sys;
  logic cpuReady;
  mmuPkg::cp15Write cp15;
  logic dataAbort;
  logic prefetchAbort;

  logic [31:0] mem [bit [31:0]];  // Page-table and data memory
  int memVersion = 0;
  int cycleCount = 0;
  int errorCount = 0;
  int testErrors = 0;
  int testsRun = 0;
  string testName;

  mmuTop u_mmuTop (
    .clk(clk), .reset(reset), .cpu(cpu), .control(control), .tableBase(tableBase),
    .domainAccess(domainAccess), .hRData(hRData), .busReady(busReady),
    .extAbort(extAbort), .sys(sys), .cpuReady(cpuReady), .cp15(cp15),
    .dataAbort(dataAbort), .prefetchAbort(prefetchAbort)
  );

  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycleCount = cycleCount + 1;
    if (cycleCount >= timeoutCycles) begin
      $display("Timeout after %0d cycles, the run did not finish", cycleCount);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] readMem(input logic [31:0] addr);
    if (mem.exists(addr)) return mem[addr];
    return 32'h0;  // Unwritten entries read as invalid descriptors
  endfunction

  always @(sys.addr or memVersion) hRData = readMem(sys.addr);

  task automatic memWrite(input logic [31:0] addr, input logic [31:0] data);
    mem[addr] = data;
    memVersion++;
  endtask

  function automatic logic [31:0] l1Addr(input logic [31:0] va);
    return {tableBase, va[31:20], 2'b00};
  endfunction

  function automatic logic [31:0] sectionDesc(input logic [11:0] base, input logic [1:0] ap,
                                              input logic [3:0] dom);
    return {base, 8'h00, ap, 1'b0, dom, 3'b000, 2'b10};
  endfunction

  function automatic logic [31:0] coarseDesc(input logic [21:0] base, input logic [3:0] dom);
    return {base, 1'b0, dom, 3'b000, 2'b01};
  endfunction

  function automatic logic [31:0] fineDesc(input logic [19:0] base, input logic [3:0] dom);
    return {base, 3'b000, dom, 3'b000, 2'b11};
  endfunction

  // AP decode as the architecture defines it for client domains
  function automatic logic expectApFault(input logic [1:0] ap, input logic s, input logic r,
                                         input logic sup, input logic wr);
    case (ap)
      2'b00: begin
        if (s && !r) return !sup || wr;
        if (!s && r) return wr;
        return 1'b1;
      end
      2'b01: return !sup;
      2'b10: return !sup && wr;
      default: return 1'b0;
    endcase
  endfunction

  task automatic checkValue(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Mismatch in %s: %s expected %h actual %h", testName, what, expected, actual);
      testErrors++;
    end
  endtask

  task automatic reportFailure(input string msg);
    $display("Error in %s: %s", testName, msg);
    testErrors++;
  endtask

  task automatic startTest(input string name);
    testName = name;
    testErrors = 0;
  endtask

  task automatic endTest();
    $display("Test %s finished with %0d errors", testName, testErrors);
    errorCount += testErrors;
    testsRun++;
  endtask

  // One processor access; waits for cpuReady or an abort, then checks the CP15 writes
  task automatic runAccess(input logic [31:0] va, input logic wr, input logic sup,
                           input logic isData, input logic word, input logic expFault,
                           input logic [31:0] expPhys, input logic [3:0] expCode,
                           input int expDomain, input bit extOnSecond);
    int cycles;
    int completions;
    logic done;
    logic sawFault;
    logic abortData;
    cycles = 0;
    completions = 0;
    done = 1'b0;
    sawFault = 1'b0;
    abortData = 1'b0;
    @(negedge clk);
    cpu.addr = va;
    cpu.req = 1'b1;
    cpu.write = wr;
    cpu.wordAccess = word;
    cpu.dataAccess = isData;
    cpu.supMode = sup;
    while (!done && cycles < 200) begin
      busReady = ($urandom % 4) != 0;  // Random stalls
      extAbort = extOnSecond && (completions == 1);
      #3;
      if (cp15.en) reportFailure("coprocessor write outside a fault sequence");
      if (dataAbort || prefetchAbort) begin
        sawFault = 1'b1;
        abortData = dataAbort;
        done = 1'b1;
        checkValue("bus write on abort", 32'h0, {31'h0, sys.write});
        if (cpuReady) reportFailure("cpuReady high together with an abort");
      end else if (cpuReady) begin
        done = 1'b1;
        checkValue("physical address", expPhys, sys.addr);
        checkValue("bus write", {31'h0, wr}, {31'h0, sys.write});
      end else if (sys.req && busReady) begin
        completions++;
      end
      cycles++;
      if (!done) @(negedge clk);
    end
    if (!done) reportFailure("access got neither cpuReady nor an abort");
    @(negedge clk);
    cpu.req = 1'b0;
    extAbort = 1'b0;
    busReady = 1'b1;
    if (expFault) begin
      if (!sawFault) reportFailure("expected an abort but the access completed");
      checkValue("abort is data", {31'h0, isData}, {31'h0, abortData});
      #3;
      checkValue("FSR write enable", 32'h1, {31'h0, cp15.en});
      checkValue("FSR register", 32'd5, {28'h0, cp15.addr});
      checkValue("fault code", {28'h0, expCode}, {28'h0, cp15.data[3:0]});
      if (expDomain >= 0) checkValue("fault domain", expDomain, {28'h0, cp15.data[7:4]});
      @(negedge clk);
      #3;
      checkValue("FAR write enable", 32'h1, {31'h0, cp15.en});
      checkValue("FAR register", 32'd6, {28'h0, cp15.addr});
      checkValue("fault address", va, cp15.data);
      @(negedge clk);
      if (cp15.en) reportFailure("coprocessor write continued after the FAR");
    end else if (sawFault) begin
      reportFailure("unexpected abort");
    end
  endtask

  task automatic testPassThrough();
    logic held;
    startTest("passThrough");
    control.enable = 1'b0;
    held = 1'b0;
    repeat (50) begin
      @(negedge clk);
      if (!held) cpu = mmuPkg::cpuBus'({$urandom, 5'($urandom)});
      busReady = 1'($urandom % 2);
      #3;
      checkValue("sys addr", cpu.addr, sys.addr);
      checkValue("sys req", {31'h0, cpu.req}, {31'h0, sys.req});
      checkValue("sys write", {31'h0, cpu.write}, {31'h0, sys.write});
      checkValue("cpuReady", {31'h0, busReady}, {31'h0, cpuReady});
      if (dataAbort || prefetchAbort) reportFailure("abort while the MMU is off");
      held = cpu.req && !busReady;  // Processor holds a stalled request
    end
    @(negedge clk);
    busReady = 1'b1;  // A stalled request completes before the MMU is enabled
    @(negedge clk);
    cpu.req = 1'b0;
    control.enable = 1'b1;
    endTest();
  endtask

  task automatic testTranslations();
    logic [31:0] va;
    startTest("translations");
    va = 32'h0031_2344;
    memWrite(l1Addr(va), sectionDesc(12'hA05, 2'b11, 4'd1));
    runAccess(va, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0, {12'hA05, va[19:0]}, 4'h0, -1, 1'b0);
    va = 32'h0050_3ABC;
    memWrite(l1Addr(va), coarseDesc(22'h002000, 4'd1));
    memWrite({22'h002000, va[19:12], 2'b00}, {20'h12345, 8'hFF, 2'b00, 2'b10});
    runAccess(va, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, {20'h12345, va[11:0]}, 4'h0, -1, 1'b0);
    va = 32'h0060_7ABC;
    memWrite(l1Addr(va), coarseDesc(22'h002004, 4'd1));
    memWrite({22'h002004, va[19:12], 2'b00}, {16'hBEEF, 4'h0, 8'hFF, 2'b00, 2'b01});
    runAccess(va, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, {16'hBEEF, va[15:0]}, 4'h0, -1, 1'b0);
    va = 32'h0070_9ABC;
    memWrite(l1Addr(va), fineDesc(20'h00900, 4'd1));
    memWrite({20'h00900, va[19:10], 2'b00}, {22'h012345, 4'h0, 2'b11, 2'b00, 2'b11});
    runAccess(va, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, {22'h012345, va[9:0]}, 4'h0, -1, 1'b0);
    endTest();
  endtask

  task automatic testTranslationFaults();
    startTest("translationFaults");
    runAccess(32'h0ABC_0010, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 32'h0,
              mmuPkg::translationSection, -1, 1'b0);
    memWrite(l1Addr(32'h0080_0000), coarseDesc(22'h003000, 4'd7));  // Empty level-2 table
    runAccess(32'h0080_5120, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 32'h0,
              mmuPkg::translationPage, 7, 1'b0);
    endTest();
  endtask

  task automatic testDomains();
    logic [31:0] va;
    startTest("domains");
    domainAccess = 32'h5555_55C5;  // Domain 2 no access, domain 3 manager
    memWrite(l1Addr(32'h0200_0000), sectionDesc(12'h300, 2'b11, 4'd2));
    runAccess(32'h0200_0040, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 32'h0,
              mmuPkg::domainSection, 2, 1'b0);
    memWrite(l1Addr(32'h0210_0000), coarseDesc(22'h003400, 4'd2));
    memWrite({22'h003400, 8'h01, 2'b00}, {20'h44444, 8'hFF, 2'b00, 2'b10});
    runAccess(32'h0210_1040, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 32'h0,
              mmuPkg::domainPage, 2, 1'b0);
    va = 32'h0220_0080;
    memWrite(l1Addr(va), sectionDesc(12'h310, 2'b01, 4'd3));
    runAccess(va, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, {12'h310, va[19:0]}, 4'h0, -1, 1'b0);
    domainAccess = 32'h5555_5555;
    endTest();
  endtask

  task automatic testPermissions();
    logic [31:0] va;
    logic [1:0] ap;
    logic [7:0] aps;
    logic exp;
    logic sup;
    logic wr;
    startTest("permissions");
    for (int a = 0; a < 4; a++) begin
      ap = a[1:0];
      va = {12'h100 + 12'(a), 20'h00450};
      memWrite(l1Addr(va), sectionDesc(12'h200 + 12'(a), ap, 4'd1));
      for (int m = 0; m < 16; m++) begin
        control.sBit = m[3];
        control.rBit = m[2];
        exp = expectApFault(ap, m[3], m[2], m[1], m[0]);
        runAccess(va, m[0], m[1], 1'b1, 1'b0, exp, {12'h200 + 12'(a), va[19:0]},
                  mmuPkg::permissionSection, 1, 1'b0);
      end
    end
    control.sBit = 1'b0;
    control.rBit = 1'b0;
    aps = {2'b11, 2'b00, 2'b01, 2'b10};  // Subpages 3 down to 0
    // User write, supervisor write and user read tell the four AP values apart
    for (int i = 0; i < 4; i++) begin
      for (int m = 0; m < 3; m++) begin
        sup = (m == 1);
        wr = (m != 2);
        exp = expectApFault(aps[2*i +: 2], 1'b0, 1'b0, sup, wr);
        va = 32'h0050_3000 | (i << 10);
        memWrite({22'h002000, va[19:12], 2'b00}, {20'h12345, aps, 2'b00, 2'b10});
        runAccess(va, wr, sup, 1'b1, 1'b0, exp, {20'h12345, va[11:0]},
                  mmuPkg::permissionPage, 1, 1'b0);
        va = 32'h0060_0000 | (i << 14);
        memWrite({22'h002004, va[19:12], 2'b00}, {16'hBEEF, 4'h0, aps, 2'b00, 2'b01});
        runAccess(va, wr, sup, 1'b1, 1'b0, exp, {16'hBEEF, va[15:0]},
                  mmuPkg::permissionPage, 1, 1'b0);
      end
    end
    endTest();
  endtask

  task automatic testAlignAndAbort();
    startTest("alignAndAbort");
    runAccess(32'h0031_0001, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1, 32'h0,
              mmuPkg::alignFault, -1, 1'b0);
    runAccess(32'h0050_3010, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 32'h0,
              mmuPkg::externalSecond, 1, 1'b1);
    endTest();
  endtask

  initial begin
    void'($urandom(32'hf068_ee7b));
    cpu = '0;
    control = '0;
    control.enable = 1'b1;
    tableBase = 18'h00010;
    domainAccess = 32'h5555_5555;  // All domains client
    busReady = 1'b1;
    extAbort = 1'b0;
    repeat (16) @(negedge clk);
    reset = 1'b0;
    testPassThrough();
    testTranslations();
    testTranslationFaults();
    testDomains();
    testPermissions();
    testAlignAndAbort();
    $display("Tests run %0d, errors %0d", testsRun, errorCount);
    if (errorCount == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
rtl/mmuPkg.sv
rtl/permissionChecker.sv
rtl/tableWalker.sv
rtl/faultReporter.sv
rtl/mmuTop.sv
verification/mmuTop_asserts.sv
verification/mmuTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= mmuTb
FILELIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
SIM_BIN ?= mmuSim
VFLAGS ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(SIM_BIN)
	-./$(BUILD_DIR)/$(SIM_BIN) | tee $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "ALL TESTS PASSED" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
